/* logic/cache_pkg.sv */
// cache sizes and types
package cache_pkg;

  // array geometry
  localparam int num_ways   = 4;
  localparam int num_sets   = 8;
  localparam int set_bits   = 3;
  localparam int tag_bits   = 10;
  localparam int data_bits  = 64;
  localparam int way_bits   = $clog2(num_ways);

  // port counts
  localparam int wr_ports   = 2;

  // victim buffer depth
  localparam int vb_entries = 4;

  // b0 picks the pair, b1 and b2 pick within a pair
  localparam int plru_bits  = 3;

  typedef struct packed {
    logic [data_bits-1:0] data;
    logic [tag_bits-1:0]  tag;
    logic                 valid;
    logic                 dirty;
  } cache_line_t;

  typedef struct packed {
    cache_line_t [num_ways-1:0] lines;
  } cache_set_t;

  typedef struct packed {
    logic                en;
    logic [set_bits-1:0] idx;
    logic [tag_bits-1:0] tag;
  } rd_req_t;

  typedef struct packed {
    logic                 en;
    logic [set_bits-1:0]  idx;
    logic [tag_bits-1:0]  tag;
    logic [data_bits-1:0] data;
    logic                 dirty;
  } wr_req_t;

  // shared by the array read and the victim buffer read
  typedef struct packed {
    logic                 hit;
    logic [data_bits-1:0] data;
  } rd_resp_t;

  typedef struct packed {
    logic                valid;
    logic [set_bits-1:0] idx;
    logic [tag_bits-1:0] tag;
  } miss_t;

  // displaced line with the set it came from
  typedef struct packed {
    logic                valid;
    logic [set_bits-1:0] idx;
    cache_line_t         line;
  } victim_t;

endpackage

/* logic/tag_match.sv */
// set tag compare
`timescale 1ns/1ps

module tag_match
  import cache_pkg::*;
(
  input  cache_set_t          set,
  input  logic [tag_bits-1:0] tag,
  input  logic                en,
  output logic                hit,
  output logic [way_bits-1:0] way
);

  logic [num_ways-1:0] match;

  // only valid ways take part
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      match[w] = en && set.lines[w].valid && (set.lines[w].tag == tag);
    end
  end

  assign hit = |match;

  // match is one-hot when tags are unique in a set
  always_comb begin
    way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (match[w]) begin
        way = w[way_bits-1:0];
      end
    end
  end

endmodule

/* logic/plru_tree.sv */
// tree pseudo-LRU for one set
`timescale 1ns/1ps

module plru_tree
  import cache_pkg::*;
(
  input  logic [plru_bits-1:0] bits,
  input  logic [way_bits-1:0]  access_way,
  input  logic                 hit,
  output logic [way_bits-1:0]  way,
  output logic [plru_bits-1:0] bits_next
);

  logic [way_bits-1:0] lru_way;

  // walk the tree toward the least recently used leaf
  always_comb begin
    if (bits[0]) begin
      // upper pair
      if (bits[2]) begin
        lru_way = 2'd3;
      end else begin
        lru_way = 2'd2;
      end
    end else begin
      // lower pair
      if (bits[1]) begin
        lru_way = 2'd1;
      end else begin
        lru_way = 2'd0;
      end
    end
  end

  // a hit keeps its way, a miss fills the lru leaf
  assign way = hit ? access_way : lru_way;

  // point every node on the path away from the accessed way
  always_comb begin
    bits_next    = bits;
    bits_next[0] = ~way[1];
    if (way[1]) begin
      bits_next[2] = ~way[0];
    end else begin
      bits_next[1] = ~way[0];
    end
  end

endmodule

/* logic/cache_mem.sv */
// cache set storage
`timescale 1ns/1ps

module cache_mem
  import cache_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  rd_req_t                rd_req,
  input  wr_req_t [wr_ports-1:0] wr_req,
  output rd_resp_t               rd_resp,
  output miss_t                  rd_miss,
  output miss_t   [wr_ports-1:0] wr_miss,
  output victim_t [wr_ports-1:0] victim
);

  cache_set_t [num_sets-1:0]               sets;
  cache_set_t [num_sets-1:0]               sets_next;
  logic       [num_sets-1:0][plru_bits-1:0] plru;
  logic       [num_sets-1:0][plru_bits-1:0] plru_next;

  // read port
  logic                 rd_hit;
  logic [way_bits-1:0]  rd_way;
  logic [plru_bits-1:0] rd_bits;
  logic [plru_bits-1:0] rd_bits_next;
  cache_line_t          rd_line;

  // write ports
  logic        [wr_ports-1:0]                wr_hit;
  logic        [wr_ports-1:0][way_bits-1:0]  wr_hit_way;
  logic        [wr_ports-1:0][way_bits-1:0]  wr_way;
  logic        [wr_ports-1:0][plru_bits-1:0] wr_bits;
  logic        [wr_ports-1:0][plru_bits-1:0] wr_bits_next;
  cache_line_t [wr_ports-1:0]                wr_old;

  tag_match rd_match_i (
    .set (sets[rd_req.idx]),
    .tag (rd_req.tag),
    .en  (rd_req.en),
    .hit (rd_hit),
    .way (rd_way)
  );

  assign rd_line = sets[rd_req.idx].lines[rd_way];

  for (genvar p = 0; p < wr_ports; p++) begin : g_wr
    tag_match wr_match_i (
      .set (sets[wr_req[p].idx]),
      .tag (wr_req[p].tag),
      .en  (wr_req[p].en),
      .hit (wr_hit[p]),
      .way (wr_hit_way[p])
    );

    // a later port sees the tree left by the port before it
    if (p == 0) begin : g_first
      assign wr_bits[p] = plru[wr_req[p].idx];
    end else begin : g_chain
      assign wr_bits[p] = (wr_req[p-1].en && (wr_req[p-1].idx == wr_req[p].idx)) ?
                          wr_bits_next[p-1] : plru[wr_req[p].idx];
    end

    plru_tree wr_plru_i (
      .bits       (wr_bits[p]),
      .access_way (wr_hit_way[p]),
      .hit        (wr_hit[p]),
      .way        (wr_way[p]),
      .bits_next  (wr_bits_next[p])
    );

    // line currently sitting in the way this port will write
    assign wr_old[p] = sets[wr_req[p].idx].lines[wr_way[p]];
  end

  // read is last in the cycle order
  always_comb begin
    rd_bits = plru[rd_req.idx];
    for (int p = 0; p < wr_ports; p++) begin
      if (wr_req[p].en && (wr_req[p].idx == rd_req.idx)) begin
        rd_bits = wr_bits_next[p];
      end
    end
  end

  // the way output equals rd_way on a hit, so it is left open
  plru_tree rd_plru_i (
    .bits       (rd_bits),
    .access_way (rd_way),
    .hit        (rd_hit),
    .way        (),
    .bits_next  (rd_bits_next)
  );

  // stored hit first, then forwarding with the highest port last
  always_comb begin
    rd_resp = '0;
    if (rd_hit) begin
      rd_resp.hit  = 1'b1;
      rd_resp.data = rd_line.data;
    end
    for (int p = 0; p < wr_ports; p++) begin
      if (rd_req.en && wr_req[p].en && (wr_req[p].idx == rd_req.idx) &&
          (wr_req[p].tag == rd_req.tag)) begin
        rd_resp.hit  = 1'b1;
        rd_resp.data = wr_req[p].data;
      end
    end
  end

  assign rd_miss.valid = rd_req.en && !rd_resp.hit;
  assign rd_miss.idx   = rd_req.idx;
  assign rd_miss.tag   = rd_req.tag;

  // miss report and displaced line per port
  always_comb begin
    for (int p = 0; p < wr_ports; p++) begin
      wr_miss[p].valid = wr_req[p].en && !wr_hit[p];
      wr_miss[p].idx   = wr_req[p].idx;
      wr_miss[p].tag   = wr_req[p].tag;
      victim[p]        = '0;
      if (wr_req[p].en && !wr_hit[p] && wr_old[p].valid) begin
        victim[p].valid = 1'b1;
        victim[p].idx   = wr_req[p].idx;
        victim[p].line  = wr_old[p];
      end
    end
  end

  // fills and tree updates in port order, read hit last
  always_comb begin
    sets_next = sets;
    plru_next = plru;
    for (int p = 0; p < wr_ports; p++) begin
      if (wr_req[p].en) begin
        sets_next[wr_req[p].idx].lines[wr_way[p]].data  = wr_req[p].data;
        sets_next[wr_req[p].idx].lines[wr_way[p]].tag   = wr_req[p].tag;
        sets_next[wr_req[p].idx].lines[wr_way[p]].valid = 1'b1;
        sets_next[wr_req[p].idx].lines[wr_way[p]].dirty = wr_req[p].dirty;
        plru_next[wr_req[p].idx] = wr_bits_next[p];
      end
    end
    if (rd_hit) begin
      plru_next[rd_req.idx] = rd_bits_next;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sets <= '0;
      plru <= '0;
    end else begin
      sets <= sets_next;
      plru <= plru_next;
    end
  end

endmodule

/* logic/victim_buffer.sv */
// victim line buffer
`timescale 1ns/1ps

module victim_buffer
  import cache_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  victim_t [wr_ports-1:0] victim,
  input  miss_t                  rd_miss,
  output rd_resp_t               vb_resp
);

  localparam int ptr_bits = $clog2(vb_entries);

  victim_t [vb_entries-1:0] entries;
  victim_t [vb_entries-1:0] entries_next;
  logic    [ptr_bits-1:0]   wr_ptr;
  logic    [ptr_bits-1:0]   wr_ptr_next;
  logic    [ptr_bits-1:0]   slot;

  // valid victims take consecutive slots, port 0 first
  always_comb begin
    entries_next = entries;
    wr_ptr_next  = wr_ptr;
    for (int p = 0; p < wr_ports; p++) begin
      if (victim[p].valid) begin
        entries_next[wr_ptr_next] = victim[p];
        wr_ptr_next = wr_ptr_next + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entries <= '0;
      wr_ptr  <= '0;
    end else begin
      entries <= entries_next;
      wr_ptr  <= wr_ptr_next;
    end
  end

  // oldest to youngest, so the youngest match is the one kept
  always_comb begin
    vb_resp = '0;
    slot    = wr_ptr;
    for (int k = 0; k < vb_entries; k++) begin
      slot = wr_ptr + k[ptr_bits-1:0];
      if (rd_miss.valid && entries[slot].valid &&
          (entries[slot].idx == rd_miss.idx) &&
          (entries[slot].line.tag == rd_miss.tag)) begin
        vb_resp.hit  = 1'b1;
        vb_resp.data = entries[slot].line.data;
      end
    end
  end

endmodule

/* logic/cache_top.sv */
// cache with victim buffer
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  rd_req_t                rd_req,
  input  wr_req_t [wr_ports-1:0] wr_req,
  output rd_resp_t               rd_resp,
  output miss_t                  rd_miss,
  output miss_t   [wr_ports-1:0] wr_miss,
  output victim_t [wr_ports-1:0] victim,
  output rd_resp_t               vb_resp
);

  // main array
  cache_mem cache_mem_i (
    .clock   (clock),
    .reset   (reset),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_resp (rd_resp),
    .rd_miss (rd_miss),
    .wr_miss (wr_miss),
    .victim  (victim)
  );

  // searched only on an array read miss
  victim_buffer victim_buffer_i (
    .clock   (clock),
    .reset   (reset),
    .victim  (victim),
    .rd_miss (rd_miss),
    .vb_resp (vb_resp)
  );

endmodule

/* tests/cache_properties.sv */
// cache interface assertions
`timescale 1ns/1ps

module cache_properties
  import cache_pkg::*;
(
  input logic                   clock,
  input logic                   reset,
  input rd_req_t                rd_req,
  input wr_req_t [wr_ports-1:0] wr_req,
  input miss_t                  rd_miss,
  input victim_t [wr_ports-1:0] victim,
  input rd_resp_t               vb_resp
);

  // design restriction on the write ports
  a_wr_sets : assert property (@(posedge clock) disable iff (reset)
    !(wr_req[0].en && wr_req[1].en && (wr_req[0].idx == wr_req[1].idx)))
    else $error("both write ports target set %0d", wr_req[0].idx);

  a_rd_miss : assert property (@(posedge clock) disable iff (reset)
    rd_miss.valid |-> rd_req.en)
    else $error("read miss reported without a read");

  a_vb_hit : assert property (@(posedge clock) disable iff (reset)
    vb_resp.hit |-> rd_miss.valid)
    else $error("victim buffer hit without an array read miss");

  for (genvar p = 0; p < wr_ports; p++) begin : g_victim
    a_victim_en : assert property (@(posedge clock) disable iff (reset)
      victim[p].valid |-> wr_req[p].en)
      else $error("victim on write port %0d without a write", p);
  end

endmodule

bind cache_top cache_properties props_i (.*);

/* include/cache_model.svh */
// cache reference model
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// state after the last modeled clock edge
cache_line_t          ref_lines [num_sets][num_ways];
logic [plru_bits-1:0] ref_tree [num_sets];
victim_t              ref_vb [vb_entries];
int                   ref_vb_ptr;

// b0 picks the pair, b1 or b2 the way inside it
function automatic int lru_way(input logic [plru_bits-1:0] b);
  if (b[0]) begin
    return b[2] ? 3 : 2;
  end
  return b[1] ? 1 : 0;
endfunction

function automatic logic [plru_bits-1:0] touch_way(input logic [plru_bits-1:0] b, input int w);
  logic [plru_bits-1:0] n;
  n = b;
  if (w < 2) begin
    n[0] = 1'b1;
    n[1] = (w == 0);
  end else begin
    n[0] = 1'b0;
    n[2] = (w == 2);
  end
  return n;
endfunction

// -1 when no valid way holds the tag
function automatic int find_way(input int idx, input logic [tag_bits-1:0] tag);
  for (int w = 0; w < num_ways; w++) begin
    if (ref_lines[idx][w].valid && ref_lines[idx][w].tag == tag) begin
      return w;
    end
  end
  return -1;
endfunction

task automatic clear_model();
  for (int s = 0; s < num_sets; s++) begin
    ref_tree[s] = '0;
    for (int w = 0; w < num_ways; w++) begin
      ref_lines[s][w] = '0;
    end
  end
  for (int k = 0; k < vb_entries; k++) begin
    ref_vb[k] = '0;
  end
  ref_vb_ptr = 0;
endtask

// outputs of one cycle, then the state update at its edge
task automatic model_step(
  input  rd_req_t                rd,
  input  wr_req_t [wr_ports-1:0] wr,
  output rd_resp_t               rd_resp,
  output miss_t                  rd_miss,
  output miss_t   [wr_ports-1:0] wr_miss,
  output victim_t [wr_ports-1:0] victim,
  output rd_resp_t               vb_resp
);
  int rd_way;
  int w;
  int slot;
  rd_way = rd.en ? find_way(rd.idx, rd.tag) : -1;
  rd_resp = '0;
  if (rd_way >= 0) begin
    rd_resp.hit  = 1'b1;
    rd_resp.data = ref_lines[rd.idx][rd_way].data;
  end
  // same-cycle writes override, higher port last
  for (int p = 0; p < wr_ports; p++) begin
    if (rd.en && wr[p].en && wr[p].idx == rd.idx && wr[p].tag == rd.tag) begin
      rd_resp.hit  = 1'b1;
      rd_resp.data = wr[p].data;
    end
  end
  rd_miss.valid = rd.en && !rd_resp.hit;
  rd_miss.idx   = rd.idx;
  rd_miss.tag   = rd.tag;
  // youngest entry first
  vb_resp = '0;
  if (rd_miss.valid) begin
    for (int k = 1; k <= vb_entries; k++) begin
      slot = (ref_vb_ptr - k + vb_entries) % vb_entries;
      if (!vb_resp.hit && ref_vb[slot].valid && ref_vb[slot].idx == rd.idx &&
          ref_vb[slot].line.tag == rd.tag) begin
        vb_resp.hit  = 1'b1;
        vb_resp.data = ref_vb[slot].line.data;
      end
    end
  end
  // ports never share a set, so applying them in order is exact
  for (int p = 0; p < wr_ports; p++) begin
    wr_miss[p].valid = 1'b0;
    wr_miss[p].idx   = wr[p].idx;
    wr_miss[p].tag   = wr[p].tag;
    victim[p]        = '0;
    if (wr[p].en) begin
      w = find_way(wr[p].idx, wr[p].tag);
      if (w < 0) begin
        wr_miss[p].valid = 1'b1;
        w = lru_way(ref_tree[wr[p].idx]);
        if (ref_lines[wr[p].idx][w].valid) begin
          victim[p].valid = 1'b1;
          victim[p].idx   = wr[p].idx;
          victim[p].line  = ref_lines[wr[p].idx][w];
        end
      end
      ref_lines[wr[p].idx][w].data  = wr[p].data;
      ref_lines[wr[p].idx][w].tag   = wr[p].tag;
      ref_lines[wr[p].idx][w].valid = 1'b1;
      ref_lines[wr[p].idx][w].dirty = wr[p].dirty;
      ref_tree[wr[p].idx] = touch_way(ref_tree[wr[p].idx], w);
    end
  end
  if (rd_way >= 0) begin
    ref_tree[rd.idx] = touch_way(ref_tree[rd.idx], rd_way);
  end
  for (int p = 0; p < wr_ports; p++) begin
    if (victim[p].valid) begin
      ref_vb[ref_vb_ptr] = victim[p];
      ref_vb_ptr = (ref_vb_ptr + 1) % vb_entries;
    end
  end
endtask

`endif

/* tests/cache_tb.sv */
// cache testbench
`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*;
;

  localparam int num_steps    = 60;
  localparam int reset_cycles = 8;
  localparam int clock_period = 10;

  typedef enum logic [1:0] {
    step_idle,
    step_read,
    step_write,
    step_read_write
  } step_kind_t;

  typedef struct packed {
    rd_req_t                   rd;
    wr_req_t  [wr_ports-1:0]   wr;
    rd_resp_t                  exp_rd_resp;
    miss_t                     exp_rd_miss;
    miss_t    [wr_ports-1:0]   exp_wr_miss;
    victim_t  [wr_ports-1:0]   exp_victim;
    rd_resp_t                  exp_vb_resp;
  } step_t;

  logic                   clock;
  logic                   reset;
  rd_req_t                rd_req;
  wr_req_t [wr_ports-1:0] wr_req;
  rd_resp_t               rd_resp;
  miss_t                  rd_miss;
  miss_t   [wr_ports-1:0] wr_miss;
  victim_t [wr_ports-1:0] victim;
  rd_resp_t               vb_resp;

  step_t  steps [num_steps];
  int     step_count;
  int     errors;
  integer seed;

  `include "cache_model.svh"

  cache_top dut_i (
    .clock   (clock),
    .reset   (reset),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_resp (rd_resp),
    .rd_miss (rd_miss),
    .wr_miss (wr_miss),
    .victim  (victim),
    .vb_resp (vb_resp)
  );

  always #(clock_period / 2) clock = ~clock;

  function automatic rd_req_t read_of(input int idx, input int tag);
    rd_req_t r;
    r.en  = 1'b1;
    r.idx = idx[set_bits-1:0];
    r.tag = tag[tag_bits-1:0];
    return r;
  endfunction

  function automatic wr_req_t write_of(input int idx, input int tag,
                                      input logic [data_bits-1:0] data, input logic dirty);
    wr_req_t w;
    w.en    = 1'b1;
    w.idx   = idx[set_bits-1:0];
    w.tag   = tag[tag_bits-1:0];
    w.data  = data;
    w.dirty = dirty;
    return w;
  endfunction

  // the step kind masks off the ports it does not use
  task automatic add_step(input step_kind_t kind, input rd_req_t r,
                          input wr_req_t w0, input wr_req_t w1);
    steps[step_count] = '0;
    steps[step_count].rd = r;
    steps[step_count].wr[0] = w0;
    steps[step_count].wr[1] = w1;
    if (kind == step_idle || kind == step_write) begin
      steps[step_count].rd.en = 1'b0;
    end
    if (kind == step_idle || kind == step_read) begin
      steps[step_count].wr[0].en = 1'b0;
      steps[step_count].wr[1].en = 1'b0;
    end
    step_count++;
  endtask

  task automatic build_table();
    int i0;
    wr_req_t w0;
    wr_req_t w1;
    step_count = 0;
    add_step(step_idle, '0, '0, '0);
    add_step(step_read, read_of(0, 5), '0, '0);
    add_step(step_write, '0, write_of(0, 5, 64'ha5a5_0000_1111_0005, 1'b0), '0);
    add_step(step_read, read_of(0, 5), '0, '0);
    // forwarding, then a write hit
    add_step(step_read_write, read_of(1, 7), write_of(1, 7, 64'hb0b0_2222_0000_0007, 1'b1), '0);
    add_step(step_write, '0, write_of(1, 7, 64'hc0c0_3333_0000_0007, 1'b0), '0);
    add_step(step_read, read_of(1, 7), '0, '0);
    // fill set 2, touch ways 2 and 1, evict way 3
    for (int t = 10; t < 14; t++) begin
      add_step(step_write, '0, write_of(2, t, 64'hd000_0000_0000_0000 + t, t[0]), '0);
    end
    add_step(step_read, read_of(2, 11), '0, '0);
    add_step(step_read, read_of(2, 12), '0, '0);
    add_step(step_write, '0, write_of(2, 14, 64'hd000_0000_0000_000e, 1'b0), '0);
    add_step(step_read, read_of(2, 13), '0, '0);
    // four more evictions push tag 13 out of the buffer
    for (int t = 15; t < 19; t++) begin
      add_step(step_write, '0, write_of(2, t, 64'hd100_0000_0000_0000 + t, 1'b1), '0);
    end
    add_step(step_read, read_of(2, 13), '0, '0);
    // dual writes on sets 3 and 4, the last pair evicts on both ports
    for (int k = 0; k < 5; k++) begin
      add_step(step_write, '0, write_of(3, 20 + k, 64'he300_0000_0000_0000 + k, k[0]),
               write_of(4, 30 + k, 64'he400_0000_0000_0000 + k, !k[0]));
    end
    add_step(step_read, read_of(3, 20), '0, '0);
    add_step(step_read, read_of(4, 30), '0, '0);
    // three more evictions overwrite the port 0 entry but keep the port 1 entry
    for (int t = 40; t < 43; t++) begin
      add_step(step_write, '0, write_of(2, t, 64'hd200_0000_0000_0000 + t, 1'b0), '0);
    end
    add_step(step_read, read_of(3, 20), '0, '0);
    add_step(step_read, read_of(4, 30), '0, '0);
    add_step(step_read_write, read_of(5, 1), write_of(5, 1, 64'hf500_0000_0000_0001, 1'b0),
             write_of(6, 2, 64'hf600_0000_0000_0002, 1'b1));
    // random mix on a few sets and tags so that hits and evictions happen
    while (step_count < num_steps) begin
      i0 = {$random(seed)} % 4;
      w0 = write_of(i0, {$random(seed)} % 6, {$random(seed), $random(seed)},
                    {$random(seed)} % 2);
      w1 = write_of((i0 + 1 + {$random(seed)} % 3) % 4, {$random(seed)} % 6,
                    {$random(seed), $random(seed)}, {$random(seed)} % 2);
      w1.en = {$random(seed)} % 2;
      add_step(step_kind_t'({$random(seed)} % 4),
               read_of({$random(seed)} % 4, {$random(seed)} % 6), w0, w1);
    end
  endtask

  task automatic check_rd_resp(input string name, input rd_resp_t exp, input rd_resp_t act);
    if (act.hit !== exp.hit || (exp.hit && act.data !== exp.data)) begin
      errors++;
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_miss(input string name, input miss_t exp, input miss_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  // the line only matters when a victim is reported
  task automatic check_victim(input string name, input victim_t exp, input victim_t act);
    if (act.valid !== exp.valid || (exp.valid && act !== exp)) begin
      errors++;
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_vb_resp(input string name, input rd_resp_t exp, input rd_resp_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  initial begin
    #((num_steps + reset_cycles) * clock_period * 2);
    $display("watchdog expired before all steps were applied");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    clock  = 1'b0;
    reset  = 1'b1;
    rd_req = '0;
    wr_req = '0;
    errors = 0;
    seed   = 81511;
    build_table();
    clear_model();
    for (int i = 0; i < num_steps; i++) begin
      model_step(steps[i].rd, steps[i].wr, steps[i].exp_rd_resp, steps[i].exp_rd_miss,
                 steps[i].exp_wr_miss, steps[i].exp_victim, steps[i].exp_vb_resp);
    end
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < num_steps; i++) begin
      if (i > 0) begin
        @(negedge clock);
      end
      rd_req = steps[i].rd;
      wr_req = steps[i].wr;
      #1;
      check_rd_resp($sformatf("step %0d rd_resp", i), steps[i].exp_rd_resp, rd_resp);
      check_miss($sformatf("step %0d rd_miss", i), steps[i].exp_rd_miss, rd_miss);
      for (int p = 0; p < wr_ports; p++) begin
        check_miss($sformatf("step %0d wr_miss[%0d]", i, p), steps[i].exp_wr_miss[p],
                   wr_miss[p]);
        check_victim($sformatf("step %0d victim[%0d]", i, p), steps[i].exp_victim[p],
                     victim[p]);
      end
      check_vb_resp($sformatf("step %0d vb_resp", i), steps[i].exp_vb_resp, vb_resp);
    end
    @(negedge clock);
    rd_req = '0;
    wr_req = '0;
    $display("cache_tb finished %0d steps with %0d errors", num_steps, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
logic/cache_pkg.sv
logic/tag_match.sv
logic/plru_tree.sv
logic/cache_mem.sv
logic/victim_buffer.sv
logic/cache_top.sv
tests/cache_properties.sv
tests/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - logic/cache_pkg.sv
  - logic/tag_match.sv
  - logic/plru_tree.sv
  - logic/cache_mem.sv
  - logic/victim_buffer.sv
  - logic/cache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cache_properties.sv
      - tests/cache_tb.sv
